// File: bridge_consts.svh
//////////////////////////////////////////////////////////////////////
// Width and depth constants for the AXI-lite write to Wishbone bridge
// Included by both type packages and by the RTL that sizes counters
//////////////////////////////////////////////////////////////////////
`ifndef BRIDGE_CONSTS_SVH
`define BRIDGE_CONSTS_SVH

// Data word width on both buses
`define BRIDGE_DATA_WIDTH 32

// AXI byte address width
`define BRIDGE_ADDR_WIDTH 28

// Log2 of the in-flight write depth
`define BRIDGE_LGFIFO 3

`endif

// File: axil_pkg.sv
//////////////////////////////////////////////////////////////////////
// AXI-lite write side types
// Address, data, strobe and response code of the slave port
//////////////////////////////////////////////////////////////////////
`include "bridge_consts.svh"

package axil_pkg;

	// Byte address as seen on awaddr
	typedef logic [`BRIDGE_ADDR_WIDTH-1:0] axil_addr_t;

	// Write data and its byte strobes
	typedef logic [`BRIDGE_DATA_WIDTH-1:0] axil_data_t;
	typedef logic [`BRIDGE_DATA_WIDTH/8-1:0] axil_strb_t;

	// Write response codes, EXOKAY never used on AXI-lite
	typedef enum logic [1:0]
	{
		OKAY   = 2'b00,
		SLVERR = 2'b10,
		DECERR = 2'b11
	} axil_resp_t;

endpackage

// File: wb_pkg.sv
//////////////////////////////////////////////////////////////////////
// Pipelined Wishbone master side types
// Word address, data and byte select of the bus
//////////////////////////////////////////////////////////////////////
`include "bridge_consts.svh"

package wb_pkg;

	// Word address, the byte address without its two low bits
	typedef logic [`BRIDGE_ADDR_WIDTH-3:0] wb_addr_t;

	// Data word
	typedef logic [`BRIDGE_DATA_WIDTH-1:0] wb_data_t;

	// One select bit per byte lane
	typedef logic [`BRIDGE_DATA_WIDTH/8-1:0] wb_sel_t;

endpackage

// File: axil_write_join.sv
//////////////////////////////////////////////////////////////////////
// Joins the AXI-lite write address and write data channels
// Holds whichever half comes first and fires one accept per pair
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`include "bridge_consts.svh"

module axil_write_join
	import axil_pkg::*;
	import wb_pkg::*;
(
	input  logic       i_clk,
	input  logic       i_reset,
	input  logic       i_awvalid,
	input  axil_addr_t i_awaddr,
	input  logic       i_wvalid,
	input  axil_data_t i_wdata,
	input  axil_strb_t i_wstrb,
	input  logic       i_bus_stall,
	input  logic       i_accept_block,
	input  logic       i_last_slot,
	input  logic       i_bresp_taken,
	input  logic       i_issue_ready,
	output logic       o_awready,
	output logic       o_wready,
	output logic       o_accept,
	output wb_addr_t   o_addr,
	output wb_data_t   o_data,
	output wb_sel_t    o_sel
);

	// Holding registers for an early half
	logic     r_awvalid;
	logic     r_wvalid;
	wb_addr_t r_addr;
	wb_data_t r_data;
	wb_sel_t  r_sel;

	// A half is present if held or handed over this cycle
	logic aw_have;
	logic w_have;
	logic fifo_block_next;

	assign aw_have = r_awvalid || (i_awvalid && o_awready);
	assign w_have  = r_wvalid || (i_wvalid && o_wready);

	// Pair complete, FIFO has room and bus can take a new request
	assign o_accept = aw_have && w_have && !i_accept_block && i_issue_ready;

	// FIFO stays full or blocked, or fills with this accept
	assign fifo_block_next = !i_bresp_taken
		&& (i_accept_block || (i_last_slot && o_accept));

	// Held copy wins over the live channel
	assign o_addr = r_awvalid ? r_addr : i_awaddr[`BRIDGE_ADDR_WIDTH-1:2];
	assign o_data = r_wvalid ? r_data : i_wdata;
	assign o_sel  = r_wvalid ? r_sel : i_wstrb;

	//////////////////////////////////////////////////////////////////////
	// Holding registers

	// Capture payload on every handshake
	always_ff @(posedge i_clk)
	begin
		if (i_awvalid && o_awready)
			r_addr <= i_awaddr[`BRIDGE_ADDR_WIDTH-1:2];
		if (i_wvalid && o_wready)
		begin
			r_data <= i_wdata;
			r_sel  <= i_wstrb;
		end
	end

	// Half stays held until its pair is accepted
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			r_awvalid <= 1'b0;
			r_wvalid  <= 1'b0;
		end
		else
		begin
			r_awvalid <= aw_have && !o_accept;
			r_wvalid  <= w_have && !o_accept;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Ready generation

	// Drop ready on a held half, bus stall or a full or blocked FIFO
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			o_awready <= 1'b1;
			o_wready  <= 1'b1;
		end
		else
		begin
			o_awready <= !(aw_have && !o_accept) && !i_bus_stall && !fifo_block_next;
			o_wready  <= !(w_have && !o_accept) && !i_bus_stall && !fifo_block_next;
		end
	end

endmodule

// File: wb_write_master.sv
//////////////////////////////////////////////////////////////////////
// Pipelined Wishbone write master
// Puts each accepted write on the bus and tracks outstanding acks
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`include "bridge_consts.svh"

module wb_write_master
	import wb_pkg::*;
(
	input  logic     i_clk,
	input  logic     i_reset,
	input  logic     i_accept,
	input  wb_addr_t i_addr,
	input  wb_data_t i_data,
	input  wb_sel_t  i_sel,
	input  logic     i_wb_ack,
	input  logic     i_wb_stall,
	input  logic     i_wb_err,
	input  logic     i_err_state,
	output logic     o_wb_cyc,
	output logic     o_wb_stb,
	output wb_addr_t o_wb_addr,
	output wb_data_t o_wb_data,
	output wb_sel_t  o_wb_sel,
	output logic     o_issue_ready,
	output logic     o_bus_stall,
	output logic     o_wb_done,
	output logic     o_wb_err
);

	// Requests on the bus still waiting for ack, 0 to 8
	logic [`BRIDGE_LGFIFO:0] outstanding;

	// Bus takes the request this cycle
	logic req_taken;

	assign req_taken     = o_wb_stb && !i_wb_stall;
	assign o_issue_ready = !o_wb_stb || !i_wb_stall;
	assign o_bus_stall   = o_wb_stb && i_wb_stall;
	assign o_wb_cyc      = o_wb_stb || (outstanding != '0);

	// Completion events seen by the tracker
	assign o_wb_done = o_wb_cyc && (i_wb_ack || i_wb_err);
	assign o_wb_err  = o_wb_cyc && i_wb_err;

	// Strobe held through stall, dropped at once on error
	always_ff @(posedge i_clk)
	begin
		if (i_reset || o_wb_err || i_err_state)
			o_wb_stb <= 1'b0;
		else if (i_accept)
			o_wb_stb <= 1'b1;
		else if (!i_wb_stall)
			o_wb_stb <= 1'b0;
	end

	// New request loads only when the bus is free to take it
	always_ff @(posedge i_clk)
	begin
		if (i_accept)
		begin
			o_wb_addr <= i_addr;
			o_wb_data <= i_data;
			o_wb_sel  <= i_sel;
		end
	end

	// Issued minus acknowledged
	always_ff @(posedge i_clk)
	begin
		if (i_reset || !o_wb_cyc || i_wb_err || i_err_state)
			outstanding <= '0;
		else if (req_taken && !i_wb_ack)
			outstanding <= outstanding + 1'b1;
		else if (!req_taken && i_wb_ack)
			outstanding <= outstanding - 1'b1;
	end

endmodule

// File: write_resp_tracker.sv
//////////////////////////////////////////////////////////////////////
// In-flight write tracker and AXI-lite write response generator
// Three pointers walk accepted, completed and answered writes in order
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`include "bridge_consts.svh"

module write_resp_tracker
	import axil_pkg::*;
(
	input  logic       i_clk,
	input  logic       i_reset,
	input  logic       i_accept,
	input  logic       i_wb_done,
	input  logic       i_wb_err,
	input  logic       i_bready,
	output logic       o_bvalid,
	output axil_resp_t o_bresp,
	output logic       o_bresp_taken,
	output logic       o_accept_block,
	output logic       o_last_slot,
	output logic       o_err_state
);

	// Fill levels for full and one-free
	localparam logic [`BRIDGE_LGFIFO:0] full_fill = 1 << `BRIDGE_LGFIFO;
	localparam logic [`BRIDGE_LGFIFO:0] last_fill = full_fill - 1'b1;

	// Pointers carry one extra wrap bit
	logic [`BRIDGE_LGFIFO:0] r_first;
	logic [`BRIDGE_LGFIFO:0] r_mid;
	logic [`BRIDGE_LGFIFO:0] r_last;
	logic [`BRIDGE_LGFIFO:0] next_last;
	logic [`BRIDGE_LGFIFO:0] fill;
	// Entry that took the bus error
	logic [`BRIDGE_LGFIFO:0] err_loc;

	assign next_last      = r_last + 1'b1;
	assign fill           = r_first - r_last;
	assign o_bresp_taken  = o_bvalid && i_bready;
	assign o_accept_block = (fill == full_fill) || o_err_state;
	assign o_last_slot    = (fill == last_fill);

	//////////////////////////////////////////////////////////////////////
	// Pointers

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			r_first <= '0;
			r_mid   <= '0;
			r_last  <= '0;
		end
		else
		begin
			if (i_accept)
				r_first <= r_first + 1'b1;
			// Flush walks mid up to first one entry per cycle
			if (i_wb_done)
				r_mid <= r_mid + 1'b1;
			else if (o_err_state && (r_mid != r_first))
				r_mid <= r_mid + 1'b1;
			if (o_bresp_taken)
				r_last <= next_last;
		end
	end

	always_ff @(posedge i_clk)
	begin
		if (i_wb_err)
			err_loc <= r_mid;
	end

	// Left once every tracked write is answered
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			o_err_state <= 1'b0;
		else if (r_first == r_last)
			o_err_state <= 1'b0;
		else if (i_wb_err)
			o_err_state <= 1'b1;
	end

	//////////////////////////////////////////////////////////////////////
	// Response channel

	// Valid while completed (or flushed) entries remain unanswered
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			o_bvalid <= 1'b0;
		else if (i_wb_done)
			o_bvalid <= 1'b1;
		else if (o_bresp_taken)
			o_bvalid <= o_err_state ? (next_last != r_first) : (next_last != r_mid);
	end

	// Code of the entry shown next on the response channel
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			o_bresp <= OKAY;
		else if (!o_bvalid || i_bready)
		begin
			if (!o_err_state && !i_wb_err)
				o_bresp <= OKAY;
			else if (!o_err_state)
			begin
				// Error arrives while the failing entry is next in line
				if (o_bvalid)
					o_bresp <= (r_mid == next_last) ? SLVERR : OKAY;
				else
					o_bresp <= (r_mid == r_last) ? SLVERR : OKAY;
			end
			else if (next_last == err_loc)
				o_bresp <= SLVERR;
			else if (o_bresp != OKAY)
				// Everything past the failing entry was flushed
				o_bresp <= DECERR;
		end
	end

endmodule

// File: axilwr_to_wb.sv
//////////////////////////////////////////////////////////////////////
// AXI-lite write channel to pipelined Wishbone write bridge, top level
// Shares the clock with both buses, AXI reset is active low
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module axilwr_to_wb
	import axil_pkg::*;
	import wb_pkg::*;
(
	input  logic       i_clk,
	input  logic       i_axi_reset_n,
	// AXI write address channel
	input  logic       i_axi_awvalid,
	output logic       o_axi_awready,
	input  axil_addr_t i_axi_awaddr,
	// AXI write data channel
	input  logic       i_axi_wvalid,
	output logic       o_axi_wready,
	input  axil_data_t i_axi_wdata,
	input  axil_strb_t i_axi_wstrb,
	// AXI write response channel
	output logic       o_axi_bvalid,
	input  logic       i_axi_bready,
	output axil_resp_t o_axi_bresp,
	// Wishbone master
	output logic       o_wb_cyc,
	output logic       o_wb_stb,
	output wb_addr_t   o_wb_addr,
	output wb_data_t   o_wb_data,
	output wb_sel_t    o_wb_sel,
	input  logic       i_wb_ack,
	input  logic       i_wb_stall,
	input  logic       i_wb_err
);

	logic w_reset;

	// Join to master
	logic     accept;
	wb_addr_t accept_addr;
	wb_data_t accept_data;
	wb_sel_t  accept_sel;

	// Master status
	logic issue_ready;
	logic bus_stall;
	logic wb_done;
	logic wb_err;

	// Tracker status
	logic accept_block;
	logic last_slot;
	logic bresp_taken;
	logic err_state;

	assign w_reset = !i_axi_reset_n;

	// Address and data pairing
	axil_write_join u_join
	(
		.i_clk          (i_clk),
		.i_reset        (w_reset),
		.i_awvalid      (i_axi_awvalid),
		.i_awaddr       (i_axi_awaddr),
		.i_wvalid       (i_axi_wvalid),
		.i_wdata        (i_axi_wdata),
		.i_wstrb        (i_axi_wstrb),
		.i_bus_stall    (bus_stall),
		.i_accept_block (accept_block),
		.i_last_slot    (last_slot),
		.i_bresp_taken  (bresp_taken),
		.i_issue_ready  (issue_ready),
		.o_awready      (o_axi_awready),
		.o_wready       (o_axi_wready),
		.o_accept       (accept),
		.o_addr         (accept_addr),
		.o_data         (accept_data),
		.o_sel          (accept_sel)
	);

	// Wishbone request side
	wb_write_master u_master
	(
		.i_clk         (i_clk),
		.i_reset       (w_reset),
		.i_accept      (accept),
		.i_addr        (accept_addr),
		.i_data        (accept_data),
		.i_sel         (accept_sel),
		.i_wb_ack      (i_wb_ack),
		.i_wb_stall    (i_wb_stall),
		.i_wb_err      (i_wb_err),
		.i_err_state   (err_state),
		.o_wb_cyc      (o_wb_cyc),
		.o_wb_stb      (o_wb_stb),
		.o_wb_addr     (o_wb_addr),
		.o_wb_data     (o_wb_data),
		.o_wb_sel      (o_wb_sel),
		.o_issue_ready (issue_ready),
		.o_bus_stall   (bus_stall),
		.o_wb_done     (wb_done),
		.o_wb_err      (wb_err)
	);

	// In-order responses
	write_resp_tracker u_tracker
	(
		.i_clk          (i_clk),
		.i_reset        (w_reset),
		.i_accept       (accept),
		.i_wb_done      (wb_done),
		.i_wb_err       (wb_err),
		.i_bready       (i_axi_bready),
		.o_bvalid       (o_axi_bvalid),
		.o_bresp        (o_axi_bresp),
		.o_bresp_taken  (bresp_taken),
		.o_accept_block (accept_block),
		.o_last_slot    (last_slot),
		.o_err_state    (err_state)
	);

endmodule

// File: tb_wb_slave.sv
//////////////////////////////////////////////////////////////////////
// Pipelined Wishbone slave model for the bridge testbench
// Stall, ack delay and error address are set by hierarchical writes
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module tb_wb_slave
	import wb_pkg::*;
(
	input  logic     i_clk,
	input  logic     i_wb_cyc,
	input  logic     i_wb_stb,
	input  wb_addr_t i_wb_addr,
	input  wb_data_t i_wb_data,
	input  wb_sel_t  i_wb_sel,
	output logic     o_wb_ack,
	output logic     o_wb_stall,
	output logic     o_wb_err
);

	// Behavior knobs
	int       stall_pct;
	int       ack_delay;
	bit       rand_delay;
	bit       err_en;
	wb_addr_t err_addr;

	// Every write taken off the bus, in order
	wb_addr_t wr_addr_q[$];
	wb_data_t wr_data_q[$];
	wb_sel_t  wr_sel_q[$];

	// Writes waiting for their ack, with due cycle
	int       due_q[$];
	wb_addr_t pend_addr_q[$];
	int       cycle;
	int       delay;

	initial
	begin
		stall_pct  = 0;
		ack_delay  = 0;
		rand_delay = 0;
		err_en     = 0;
		err_addr   = '0;
		cycle      = 0;
		o_wb_ack   = 0;
		o_wb_err   = 0;
		o_wb_stall = 0;
	end

	// Take requests on the rising edge
	always @(posedge i_clk)
	begin
		cycle = cycle + 1;
		if (i_wb_cyc && i_wb_stb && !o_wb_stall)
		begin
			wr_addr_q.push_back(i_wb_addr);
			wr_data_q.push_back(i_wb_data);
			wr_sel_q.push_back(i_wb_sel);
			delay = rand_delay ? $urandom_range(ack_delay, 0) : ack_delay;
			due_q.push_back(cycle + delay);
			pend_addr_q.push_back(i_wb_addr);
		end
	end

	// Answers and stall change on the falling edge
	always @(negedge i_clk)
	begin
		o_wb_ack = 0;
		o_wb_err = 0;
		if (!i_wb_cyc)
		begin
			// Cycle dropped, pending acks are abandoned
			due_q.delete();
			pend_addr_q.delete();
		end
		else if (due_q.size() > 0 && due_q[0] <= cycle)
		begin
			if (err_en && pend_addr_q[0] == err_addr)
			begin
				o_wb_err = 1;
				due_q.delete();
				pend_addr_q.delete();
			end
			else
			begin
				o_wb_ack = 1;
				void'(due_q.pop_front());
				void'(pend_addr_q.pop_front());
			end
		end
		o_wb_stall = ($urandom_range(99, 0) < stall_pct);
	end

endmodule

// File: tb_axilwr_to_wb.sv
//////////////////////////////////////////////////////////////////////
// Testbench for the AXI-lite write to Wishbone bridge
// Runs the directed tests in sequence and is built by run_sim.sh
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module tb_axilwr_to_wb
	import axil_pkg::*;
	import wb_pkg::*;
;

	localparam int NUM_TESTS       = 5;
	localparam int CYCLES_PER_TEST = 200;
	localparam int CLK_PERIOD      = 40;

	logic       clk;
	logic       axi_reset_n;
	logic       awvalid;
	logic       awready;
	axil_addr_t awaddr;
	logic       wvalid;
	logic       wready;
	axil_data_t wdata;
	axil_strb_t wstrb;
	logic       bvalid;
	logic       bready;
	axil_resp_t bresp;
	logic       wb_cyc;
	logic       wb_stb;
	wb_addr_t   wb_addr;
	wb_data_t   wb_data;
	wb_sel_t    wb_sel;
	logic       wb_ack;
	logic       wb_stall;
	logic       wb_err;

	int errors;
	// Address handshakes and responses taken so far
	int aw_acc;
	int b_acc;
	int seed_dummy;

	// Writes offered, in order
	wb_addr_t exp_addr_q[$];
	wb_data_t exp_data_q[$];
	wb_sel_t  exp_sel_q[$];

	axilwr_to_wb DUT
	(
		.i_clk         (clk),
		.i_axi_reset_n (axi_reset_n),
		.i_axi_awvalid (awvalid),
		.o_axi_awready (awready),
		.i_axi_awaddr  (awaddr),
		.i_axi_wvalid  (wvalid),
		.o_axi_wready  (wready),
		.i_axi_wdata   (wdata),
		.i_axi_wstrb   (wstrb),
		.o_axi_bvalid  (bvalid),
		.i_axi_bready  (bready),
		.o_axi_bresp   (bresp),
		.o_wb_cyc      (wb_cyc),
		.o_wb_stb      (wb_stb),
		.o_wb_addr     (wb_addr),
		.o_wb_data     (wb_data),
		.o_wb_sel      (wb_sel),
		.i_wb_ack      (wb_ack),
		.i_wb_stall    (wb_stall),
		.i_wb_err      (wb_err)
	);

	tb_wb_slave u_slave
	(
		.i_clk      (clk),
		.i_wb_cyc   (wb_cyc),
		.i_wb_stb   (wb_stb),
		.i_wb_addr  (wb_addr),
		.i_wb_data  (wb_data),
		.i_wb_sel   (wb_sel),
		.o_wb_ack   (wb_ack),
		.o_wb_stall (wb_stall),
		.o_wb_err   (wb_err)
	);

	initial
	begin
		clk = 0;
		forever #(CLK_PERIOD/2) clk = ~clk;
	end

	// Whole run limited by the test budget
	initial
	begin
		#(NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
		$display("Timeout: the tests did not finish in %0d cycles",
			NUM_TESTS * CYCLES_PER_TEST);
		$display("CHECKS FAILED");
		$finish;
	end

	// In-flight limit of 8 on the address channel
	always @(posedge clk)
	begin
		if (aw_acc - b_acc > 8)
		begin
			errors++;
			$display("Error at %0t: %0d writes accepted ahead of responses",
				$time, aw_acc - b_acc);
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Channel drivers entered and left on a falling edge

	task automatic put_addr(input axil_addr_t a);
		logic ok;
		awaddr  = a;
		awvalid = 1;
		ok      = 0;
		while (!ok)
		begin
			ok = awready;
			@(negedge clk);
		end
		awvalid = 0;
		aw_acc++;
	endtask

	task automatic put_data(input axil_data_t d, input axil_strb_t s);
		logic ok;
		wdata  = d;
		wstrb  = s;
		wvalid = 1;
		ok     = 0;
		while (!ok)
		begin
			ok = wready;
			@(negedge clk);
		end
		wvalid = 0;
	endtask

	// Each half may lead the other by some cycles
	task automatic send_write(input axil_addr_t a, input axil_data_t d, input axil_strb_t s,
		input int aw_lead, input int w_lead);
		exp_addr_q.push_back(wb_addr_t'(a >> 2));
		exp_data_q.push_back(d);
		exp_sel_q.push_back(s);
		fork
			begin
				repeat (aw_lead) @(negedge clk);
				put_addr(a);
			end
			begin
				repeat (w_lead) @(negedge clk);
				put_data(d, s);
			end
		join
	endtask

	task automatic take_resp(output axil_resp_t r);
		while (!(bvalid && bready))
			@(negedge clk);
		r = bresp;
		@(negedge clk);
		b_acc++;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Compare tasks

	task automatic check_resp(input axil_resp_t exp, input axil_resp_t got);
		if (got !== exp)
		begin
			errors++;
			$display("MISMATCH at %0t: o_axi_bresp expected %s got %s",
				$time, exp.name(), got.name());
		end
	endtask

	task automatic check_write(input wb_addr_t ea, input wb_data_t ed, input wb_sel_t es,
		input wb_addr_t ga, input wb_data_t gd, input wb_sel_t gs);
		if (ga !== ea)
		begin
			errors++;
			$display("MISMATCH at %0t: o_wb_addr expected %h got %h", $time, ea, ga);
		end
		if (gd !== ed)
		begin
			errors++;
			$display("MISMATCH at %0t: o_wb_data expected %h got %h", $time, ed, gd);
		end
		if (gs !== es)
		begin
			errors++;
			$display("MISMATCH at %0t: o_wb_sel expected %h got %h", $time, es, gs);
		end
	endtask

	task automatic collect_resps(input int n, input axil_resp_t exp);
		axil_resp_t r;
		repeat (n)
		begin
			take_resp(r);
			check_resp(exp, r);
		end
	endtask

	// Bus writes against offered writes, in order
	task automatic check_bus_writes();
		// Every write is answered here, so the bus cycle must be closed
		if (wb_cyc !== 1'b0 || wb_stb !== 1'b0)
		begin
			errors++;
			$display("Error at %0t: Wishbone cycle still open after the last response",
				$time);
		end
		if (u_slave.wr_addr_q.size() != exp_addr_q.size())
		begin
			errors++;
			$display("Error at %0t: bus saw %0d writes but %0d were offered",
				$time, u_slave.wr_addr_q.size(), exp_addr_q.size());
		end
		while (exp_addr_q.size() > 0 && u_slave.wr_addr_q.size() > 0)
			check_write(exp_addr_q.pop_front(), exp_data_q.pop_front(), exp_sel_q.pop_front(),
				u_slave.wr_addr_q.pop_front(), u_slave.wr_data_q.pop_front(),
				u_slave.wr_sel_q.pop_front());
		exp_addr_q.delete();
		exp_data_q.delete();
		exp_sel_q.delete();
		u_slave.wr_addr_q.delete();
		u_slave.wr_data_q.delete();
		u_slave.wr_sel_q.delete();
	endtask

	//////////////////////////////////////////////////////////////////////
	// Directed tests

	task automatic single_write_test();
		send_write(28'h000_1234, 32'hdead_beef, 4'b1010, 0, 0);
		collect_resps(1, OKAY);
		check_bus_writes();
	endtask

	task automatic split_order_test();
		// Address first, then data first
		send_write(28'h0a0_0010, 32'h1357_9bdf, 4'b1111, 0, 4);
		collect_resps(1, OKAY);
		send_write(28'h0b0_0020, 32'h2468_ace0, 4'b0011, 4, 0);
		collect_resps(1, OKAY);
		check_bus_writes();
	endtask

	task automatic backpressure_test();
		bready = 0;
		fork
			for (int i = 0; i < 12; i++)
				send_write(axil_addr_t'(28'h100_0000 + i * 4), 32'hc0de_0000 + i, 4'hf, 0, 0);
			begin
				repeat (30) @(negedge clk);
				// With no responses taken the FIFO sits full
				if (aw_acc - b_acc != 8)
				begin
					errors++;
					$display("Error at %0t: %0d writes in flight with bready low, 8 expected",
						$time, aw_acc - b_acc);
				end
				bready = 1;
				collect_resps(12, OKAY);
			end
		join
		check_bus_writes();
	endtask

	task automatic bus_error_test();
		axil_resp_t r;
		u_slave.ack_delay = 6;
		u_slave.err_en    = 1;
		u_slave.err_addr  = wb_addr_t'(28'h200_0008 >> 2);
		fork
			for (int i = 0; i < 5; i++)
				send_write(axil_addr_t'(28'h200_0000 + i * 4), 32'he000_0000 + i, 4'hf, 0, 0);
			begin
				collect_resps(2, OKAY);
				take_resp(r);
				check_resp(SLVERR, r);
				collect_resps(2, DECERR);
			end
		join
		// Flushed writes were already on the bus before the error
		check_bus_writes();
		u_slave.err_en    = 0;
		u_slave.ack_delay = 0;
		send_write(28'h300_0040, 32'h600d_f00d, 4'b0110, 0, 0);
		collect_resps(1, OKAY);
		check_bus_writes();
	endtask

	task automatic random_traffic_test();
		u_slave.stall_pct  = 30;
		u_slave.rand_delay = 1;
		u_slave.ack_delay  = 3;
		fork
			for (int i = 0; i < 40; i++)
				send_write(axil_addr_t'($urandom), $urandom, axil_strb_t'($urandom_range(15, 0)),
					$urandom_range(2, 0), $urandom_range(2, 0));
			collect_resps(40, OKAY);
		join
		check_bus_writes();
		u_slave.stall_pct = 0;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Main sequence

	initial
	begin
		seed_dummy  = $urandom(32'h9234_fae0);
		errors      = 0;
		aw_acc      = 0;
		b_acc       = 0;
		axi_reset_n = 0;
		awvalid     = 0;
		awaddr      = '0;
		wvalid      = 0;
		wdata       = '0;
		wstrb       = '0;
		bready      = 1;
		repeat (3) @(negedge clk);
		axi_reset_n = 1;
		@(negedge clk);

		single_write_test();
		split_order_test();
		backpressure_test();
		bus_error_test();
		random_traffic_test();

		$display("Run finished with %0d errors", errors);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

// File: axilwr_to_wb.f
+incdir+.
axil_pkg.sv
wb_pkg.sv
axil_write_join.sv
wb_write_master.sv
write_resp_tracker.sv
axilwr_to_wb.sv
tb_wb_slave.sv
tb_axilwr_to_wb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the bridge testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal \
	--top-module tb_axilwr_to_wb \
	-f axilwr_to_wb.f \
	--Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "ALL CHECKS PASSED"; then
	exit 0
fi
exit 1
